//--- include/trdb_consts.svh
// Width and limit macros for the trace encoder; include wherever a port or counter is sized.
`ifndef TRDB_CONSTS_SVH
`define TRDB_CONSTS_SVH

// address and trap value width
`define TRDB_XLEN 32

// exception or interrupt cause
`define TRDB_CAUSE_LEN 5

// machine mode is 3
`define TRDB_PRIV_LEN 2

// branch map holds at most 31 outcomes
`define TRDB_BMAP_LEN 31
`define TRDB_BCOUNT_LEN 5

// largest packet is the trap packet of 72 bits
`define TRDB_PAYLOAD_LEN 72

// packet length in bytes
`define TRDB_PLEN_LEN 4

// qualified instructions between two forced start packets
`define TRDB_RESYNC_MAX 16

// privilege the encoder assumes out of reset
`define TRDB_PRIV_RESET 3

`endif

//--- source/trdb_pkg.sv
// Shared enums for the trace encoder; modules refer to them as trdb_pkg::name.
`default_nettype none

package trdb_pkg;

    // packet format field
    // format 0 is not produced by this encoder
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    // subformat of format 3 packets
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_subformat_e;

    // why execute decided to send a packet
    // listed from highest to lowest priority after R_NONE
    typedef enum logic [2:0] {
        R_NONE,
        R_START,
        R_TRAP,
        R_PRIVCHANGE,
        R_RESYNC,
        R_UPDISCON,
        R_BMAP_FULL
    } trdb_reason_e;

endpackage

`default_nettype wire

//--- source/trdb_decode.sv
// Instruction staging: samples the retired instruction into this and last stages for execute.
`default_nettype none
`include "trdb_consts.svh"

module trdb_decode (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        inst_valid_i,
    input  logic                        trace_enable_i,
    input  logic                        exception_i,
    input  logic                        interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]  cause_i,
    input  logic [`TRDB_XLEN-1:0]       tval_i,
    input  logic [`TRDB_PRIV_LEN-1:0]   priv_lvl_i,
    input  logic [`TRDB_XLEN-1:0]       pc_i,
    input  logic                        branch_i,
    input  logic                        branch_taken_i,
    input  logic                        updiscon_i,
    output logic                        tc_valid_o,
    output logic                        tc_qualified_o,
    output logic                        tc_first_qualified_o,
    output logic                        tc_privchange_o,
    output logic                        tc_branch_o,
    output logic                        tc_branch_taken_o,
    output logic [`TRDB_XLEN-1:0]       tc_iaddr_o,
    output logic [`TRDB_PRIV_LEN-1:0]   tc_priv_o,
    output logic                        lc_exception_o,
    output logic                        lc_interrupt_o,
    output logic [`TRDB_CAUSE_LEN-1:0]  lc_cause_o,
    output logic [`TRDB_XLEN-1:0]       lc_tval_o,
    output logic                        lc_updiscon_o
);

    // this stage
    logic                        valid_q;
    logic                        enable_q;
    logic                        exception_q;
    logic                        interrupt_q;
    logic [`TRDB_CAUSE_LEN-1:0]  cause_q;
    logic [`TRDB_XLEN-1:0]       tval_q;
    logic [`TRDB_PRIV_LEN-1:0]   priv_q;
    logic [`TRDB_XLEN-1:0]       pc_q;
    logic                        branch_q;
    logic                        taken_q;
    logic                        updiscon_q;
    // last stage, previous valid instruction
    logic                        lc_qualified_q;
    logic                        lc_exception_q;
    logic                        lc_updiscon_q;
    logic [`TRDB_PRIV_LEN-1:0]   lc_priv_q;
    logic                        lc_interrupt_q;
    logic [`TRDB_CAUSE_LEN-1:0]  lc_cause_q;
    logic [`TRDB_XLEN-1:0]       lc_tval_q;
    logic                        qualified;

    assign qualified = valid_q & enable_q;

    // strobes of the this stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            valid_q  <= inst_valid_i;
            enable_q <= trace_enable_i;
        end
    end

    // fields only matter while valid_q is high
    always_ff @(posedge clk_i) begin
        exception_q <= exception_i;
        interrupt_q <= interrupt_i;
        cause_q     <= cause_i;
        tval_q      <= tval_i;
        priv_q      <= priv_lvl_i;
        pc_q        <= pc_i;
        branch_q    <= branch_i;
        taken_q     <= branch_taken_i;
        updiscon_q  <= updiscon_i;
    end

    // last stage advances only on a valid this instruction
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lc_qualified_q <= 1'b0;
            lc_exception_q <= 1'b0;
            lc_updiscon_q  <= 1'b0;
            lc_priv_q      <= `TRDB_PRIV_LEN'(`TRDB_PRIV_RESET);
        end else if (valid_q) begin
            lc_qualified_q <= qualified;
            lc_exception_q <= exception_q;
            lc_updiscon_q  <= updiscon_q;
            lc_priv_q      <= priv_q;
        end
    end

    // trap details for the packet after an exception
    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            lc_interrupt_q <= interrupt_q;
            lc_cause_q     <= cause_q;
            lc_tval_q      <= tval_q;
        end
    end

    assign tc_valid_o           = valid_q;
    assign tc_qualified_o       = qualified;
    // tracing just switched on for this instruction
    assign tc_first_qualified_o = qualified & ~lc_qualified_q;
    assign tc_privchange_o      = valid_q & (priv_q != lc_priv_q);
    assign tc_branch_o          = branch_q;
    assign tc_branch_taken_o    = taken_q;
    assign tc_iaddr_o           = pc_q;
    assign tc_priv_o            = priv_q;
    assign lc_exception_o       = lc_exception_q;
    assign lc_interrupt_o       = lc_interrupt_q;
    assign lc_cause_o           = lc_cause_q;
    assign lc_tval_o            = lc_tval_q;
    assign lc_updiscon_o        = lc_updiscon_q;

endmodule

`default_nettype wire

//--- source/trdb_branch_map.sv
// Branch map storage: records conditional branch outcomes until execute flushes on a packet.
`default_nettype none
`include "trdb_consts.svh"

module trdb_branch_map (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         record_i,
    input  logic                         taken_i,
    input  logic                         flush_i,
    output logic [`TRDB_BMAP_LEN-1:0]    map_o,
    output logic [`TRDB_BCOUNT_LEN-1:0]  count_o,
    output logic                         full_o
);

    logic [`TRDB_BMAP_LEN-1:0]    map_q;
    logic [`TRDB_BCOUNT_LEN-1:0]  count_q;

    // no room left once count reaches capacity
    assign full_o = (count_q == `TRDB_BCOUNT_LEN'(`TRDB_BMAP_LEN));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // flush wins over a record in the same cycle
            // the recorded bit already went out in the snapshot
            map_q   <= '0;
            count_q <= '0;
        end else if (record_i && !full_o) begin
            // not taken is stored as 1
            map_q[count_q] <= ~taken_i;
            count_q        <= count_q + 1'b1;
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;

endmodule

`default_nettype wire

//--- source/trdb_execute.sv
// Packet priority for the this instruction; also owns the branch map and resync counter.
`default_nettype none
`include "trdb_consts.svh"

module trdb_execute (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         tc_valid_i,
    input  logic                         tc_qualified_i,
    input  logic                         tc_first_qualified_i,
    input  logic                         tc_privchange_i,
    input  logic                         tc_branch_i,
    input  logic                         tc_branch_taken_i,
    input  logic                         lc_exception_i,
    input  logic                         lc_updiscon_i,
    output logic                         emit_o,
    output trdb_pkg::trdb_reason_e       reason_o,
    output logic [`TRDB_BCOUNT_LEN-1:0]  bcount_o,
    output logic [`TRDB_BMAP_LEN-1:0]    bmap_o
);

    logic                                  qual;
    logic                                  add_branch;
    logic                                  resync_due;
    logic                                  sync_pkt;
    logic [`TRDB_BMAP_LEN-1:0]             map;
    logic [`TRDB_BCOUNT_LEN-1:0]           count;
    logic                                  map_full;
    logic [$clog2(`TRDB_RESYNC_MAX)-1:0]   resync_q;
    trdb_pkg::trdb_reason_e                reason;

    // qualified already implies valid
    assign qual       = tc_valid_i & tc_qualified_i;
    assign add_branch = qual & tc_branch_i & ~map_full;

    trdb_branch_map i_branch_map (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .record_i (add_branch),
        .taken_i  (tc_branch_taken_i),
        .flush_i  (emit_o),
        .map_o    (map),
        .count_o  (count),
        .full_o   (map_full)
    );

    // stored map plus the outcome of this branch
    always_comb begin
        bmap_o   = map;
        bcount_o = count;
        if (add_branch) begin
            bmap_o[count] = ~tc_branch_taken_i;
            bcount_o      = count + 1'b1;
        end
    end

    assign resync_due = (32'(resync_q) == `TRDB_RESYNC_MAX - 1);

    // fixed priority, highest first
    always_comb begin
        reason = trdb_pkg::R_NONE;
        if (qual) begin
            if (tc_first_qualified_i) begin
                reason = trdb_pkg::R_START;
            end else if (lc_exception_i) begin
                reason = trdb_pkg::R_TRAP;
            end else if (tc_privchange_i) begin
                reason = trdb_pkg::R_PRIVCHANGE;
            end else if (resync_due) begin
                reason = trdb_pkg::R_RESYNC;
            end else if (lc_updiscon_i) begin
                reason = trdb_pkg::R_UPDISCON;
            end else if (bcount_o == `TRDB_BCOUNT_LEN'(`TRDB_BMAP_LEN)) begin
                reason = trdb_pkg::R_BMAP_FULL;
            end
        end
    end

    // format 3 reasons restart the resync window
    assign sync_pkt = reason inside {trdb_pkg::R_START, trdb_pkg::R_TRAP,
                                     trdb_pkg::R_PRIVCHANGE, trdb_pkg::R_RESYNC};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resync_q <= '0;
        end else if (qual) begin
            if (sync_pkt) begin
                resync_q <= '0;
            end else begin
                resync_q <= resync_q + 1'b1;
            end
        end
    end

    assign reason_o = reason;
    assign emit_o   = (reason != trdb_pkg::R_NONE);

endmodule

`default_nettype wire

//--- source/trdb_result.sv
// Packet assembly: picks format and payload layout from the reason and registers the packet.
`default_nettype none
`include "trdb_consts.svh"

module trdb_result (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          emit_i,
    input  trdb_pkg::trdb_reason_e        reason_i,
    input  logic [`TRDB_BCOUNT_LEN-1:0]   bcount_i,
    input  logic [`TRDB_BMAP_LEN-1:0]     bmap_i,
    input  logic [`TRDB_XLEN-1:0]         tc_iaddr_i,
    input  logic [`TRDB_PRIV_LEN-1:0]     tc_priv_i,
    input  logic                          lc_interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]    lc_cause_i,
    input  logic [`TRDB_XLEN-1:0]         lc_tval_i,
    output logic                          packet_valid_o,
    output logic [1:0]                    packet_format_o,
    output logic [1:0]                    packet_subformat_o,
    output logic [`TRDB_PLEN_LEN-1:0]     packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]  packet_payload_o
);

    logic [1:0]                    format_d;
    logic [1:0]                    subformat_d;
    logic [`TRDB_PLEN_LEN-1:0]     length_d;
    logic [`TRDB_PAYLOAD_LEN-1:0]  payload_d;

    // fields packed lsb first and upper bits left at zero
    always_comb begin
        format_d    = '0;
        subformat_d = '0;
        length_d    = '0;
        payload_d   = '0;
        if (emit_i) begin
            case (reason_i)
                trdb_pkg::R_START, trdb_pkg::R_PRIVCHANGE, trdb_pkg::R_RESYNC: begin
                    format_d    = trdb_pkg::F_SYNC;
                    subformat_d = trdb_pkg::SF_START;
                    length_d    = `TRDB_PLEN_LEN'(5);
                    payload_d   = `TRDB_PAYLOAD_LEN'({tc_iaddr_i, tc_priv_i});
                end
                trdb_pkg::R_TRAP: begin
                    format_d    = trdb_pkg::F_SYNC;
                    subformat_d = trdb_pkg::SF_TRAP;
                    length_d    = `TRDB_PLEN_LEN'(9);
                    payload_d   = `TRDB_PAYLOAD_LEN'({lc_tval_i, lc_cause_i, lc_interrupt_i,
                                                      tc_iaddr_i, tc_priv_i});
                end
                trdb_pkg::R_UPDISCON, trdb_pkg::R_BMAP_FULL: begin
                    // jump with nothing in the map needs only the address
                    if (reason_i == trdb_pkg::R_UPDISCON && bcount_i == '0) begin
                        format_d  = trdb_pkg::F_ADDR_ONLY;
                        length_d  = `TRDB_PLEN_LEN'(4);
                        payload_d = `TRDB_PAYLOAD_LEN'(tc_iaddr_i);
                    end else begin
                        format_d  = trdb_pkg::F_BRANCH_FULL;
                        length_d  = `TRDB_PLEN_LEN'(9);
                        payload_d = `TRDB_PAYLOAD_LEN'({tc_iaddr_i, bmap_i, bcount_i});
                    end
                end
                default: ;
            endcase
        end
    end

    // one-cycle pulse and everything zero between packets
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o     <= 1'b0;
            packet_format_o    <= '0;
            packet_subformat_o <= '0;
            packet_length_o    <= '0;
            packet_payload_o   <= '0;
        end else begin
            packet_valid_o     <= emit_i;
            packet_format_o    <= format_d;
            packet_subformat_o <= subformat_d;
            packet_length_o    <= length_d;
            packet_payload_o   <= payload_d;
        end
    end

endmodule

`default_nettype wire

//--- source/trace_debugger.sv
// Trace encoder top level; connect the core retire port and take packets from the outputs.
`default_nettype none
`include "trdb_consts.svh"

module trace_debugger (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          inst_valid_i,
    input  logic                          trace_enable_i,
    input  logic                          exception_i,
    input  logic                          interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]    cause_i,
    input  logic [`TRDB_XLEN-1:0]         tval_i,
    input  logic [`TRDB_PRIV_LEN-1:0]     priv_lvl_i,
    input  logic [`TRDB_XLEN-1:0]         pc_i,
    input  logic                          branch_i,
    input  logic                          branch_taken_i,
    input  logic                          updiscon_i,
    output logic                          packet_valid_o,
    output logic [1:0]                    packet_format_o,
    output logic [1:0]                    packet_subformat_o,
    output logic [`TRDB_PLEN_LEN-1:0]     packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]  packet_payload_o
);

    // this stage
    logic                         tc_valid;
    logic                         tc_qualified;
    logic                         tc_first_qualified;
    logic                         tc_privchange;
    logic                         tc_branch;
    logic                         tc_branch_taken;
    logic [`TRDB_XLEN-1:0]        tc_iaddr;
    logic [`TRDB_PRIV_LEN-1:0]    tc_priv;
    // last stage
    logic                         lc_exception;
    logic                         lc_interrupt;
    logic [`TRDB_CAUSE_LEN-1:0]   lc_cause;
    logic [`TRDB_XLEN-1:0]        lc_tval;
    logic                         lc_updiscon;
    // execute to result
    logic                         emit;
    trdb_pkg::trdb_reason_e       reason;
    logic [`TRDB_BCOUNT_LEN-1:0]  bcount;
    logic [`TRDB_BMAP_LEN-1:0]    bmap;

    trdb_decode i_decode (
        .clk_i, .rst_ni, .inst_valid_i, .trace_enable_i, .exception_i, .interrupt_i,
        .cause_i, .tval_i, .priv_lvl_i, .pc_i, .branch_i, .branch_taken_i, .updiscon_i,
        .tc_valid_o           (tc_valid),
        .tc_qualified_o       (tc_qualified),
        .tc_first_qualified_o (tc_first_qualified),
        .tc_privchange_o      (tc_privchange),
        .tc_branch_o          (tc_branch),
        .tc_branch_taken_o    (tc_branch_taken),
        .tc_iaddr_o           (tc_iaddr),
        .tc_priv_o            (tc_priv),
        .lc_exception_o       (lc_exception),
        .lc_interrupt_o       (lc_interrupt),
        .lc_cause_o           (lc_cause),
        .lc_tval_o            (lc_tval),
        .lc_updiscon_o        (lc_updiscon)
    );

    trdb_execute i_execute (
        .clk_i, .rst_ni,
        .tc_valid_i           (tc_valid),
        .tc_qualified_i       (tc_qualified),
        .tc_first_qualified_i (tc_first_qualified),
        .tc_privchange_i      (tc_privchange),
        .tc_branch_i          (tc_branch),
        .tc_branch_taken_i    (tc_branch_taken),
        .lc_exception_i       (lc_exception),
        .lc_updiscon_i        (lc_updiscon),
        .emit_o               (emit),
        .reason_o             (reason),
        .bcount_o             (bcount),
        .bmap_o               (bmap)
    );

    // packet leaves one cycle after the execute decision
    trdb_result i_result (
        .clk_i, .rst_ni,
        .emit_i         (emit),
        .reason_i       (reason),
        .bcount_i       (bcount),
        .bmap_i         (bmap),
        .tc_iaddr_i     (tc_iaddr),
        .tc_priv_i      (tc_priv),
        .lc_interrupt_i (lc_interrupt),
        .lc_cause_i     (lc_cause),
        .lc_tval_i      (lc_tval),
        .packet_valid_o, .packet_format_o, .packet_subformat_o,
        .packet_length_o, .packet_payload_o
    );

endmodule

`default_nettype wire

//--- verification/trdb_properties.sv
// Concurrent output checks for the trace encoder; bound into trace_debugger by the bind below.
`default_nettype none
`include "trdb_consts.svh"

module trdb_properties (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          inst_valid_i,
    input  logic                          packet_valid_o,
    input  logic [1:0]                    packet_format_o,
    input  logic [1:0]                    packet_subformat_o,
    input  logic [`TRDB_PLEN_LEN-1:0]     packet_length_o,
    input  logic [`TRDB_PAYLOAD_LEN-1:0]  packet_payload_o
);

    // quiet while held in reset
    assert property (@(posedge clk_i) !rst_ni |-> !packet_valid_o)
        else $error("packet_valid_o high during reset");

    // this stage was cleared, so the first edge out of reset emits nothing
    assert property (@(posedge clk_i) $rose(rst_ni) |-> !packet_valid_o)
        else $error("packet_valid_o high on reset release");
    assert property (@(posedge clk_i) $rose(rst_ni) |=> !packet_valid_o)
        else $error("packet_valid_o high in first cycle after reset");

    // a packet needs an instruction sampled two edges before
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> $past(inst_valid_i, 2))
        else $error("packet without a valid instruction two edges earlier");

    // format, subformat and length must match one packet kind
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_o |->
            (packet_format_o == trdb_pkg::F_SYNC && packet_subformat_o == trdb_pkg::SF_START
                && packet_length_o == 4'd5)
            || (packet_format_o == trdb_pkg::F_SYNC && packet_subformat_o == trdb_pkg::SF_TRAP
                && packet_length_o == 4'd9)
            || (packet_format_o == trdb_pkg::F_ADDR_ONLY && packet_length_o == 4'd4)
            || (packet_format_o == trdb_pkg::F_BRANCH_FULL && packet_length_o == 4'd9))
        else $error("packet format and length disagree");

    // payload held at zero between packets
    assert property (@(posedge clk_i) !packet_valid_o |-> packet_payload_o == '0)
        else $error("payload not zero without a packet");

endmodule

bind trace_debugger trdb_properties i_properties (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .inst_valid_i       (inst_valid_i),
    .packet_valid_o     (packet_valid_o),
    .packet_format_o    (packet_format_o),
    .packet_subformat_o (packet_subformat_o),
    .packet_length_o    (packet_length_o),
    .packet_payload_o   (packet_payload_o)
);

`default_nettype wire

//--- verification/trdb_tb.sv
// Testbench for the trace encoder; run trdb_tb as top, it checks every packet against a model.
`default_nettype none
`include "trdb_consts.svh"

module trdb_tb;

    localparam int PERIOD          = 4;
    localparam int DIRECTED_CYCLES = 90;
    localparam int RAND_COUNT      = 300;
    localparam int STIM_CYCLES     = 3 + DIRECTED_CYCLES + RAND_COUNT + 4;
    localparam int TIMEOUT         = (STIM_CYCLES + 20) * PERIOD;

    logic                          clk_i = 1'b0;
    logic                          rst_ni;
    logic                          inst_valid_i;
    logic                          trace_enable_i;
    logic                          exception_i;
    logic                          interrupt_i;
    logic [`TRDB_CAUSE_LEN-1:0]    cause_i;
    logic [`TRDB_XLEN-1:0]         tval_i;
    logic [`TRDB_PRIV_LEN-1:0]     priv_lvl_i;
    logic [`TRDB_XLEN-1:0]         pc_i;
    logic                          branch_i;
    logic                          branch_taken_i;
    logic                          updiscon_i;
    logic                          packet_valid_o;
    logic [1:0]                    packet_format_o;
    logic [1:0]                    packet_subformat_o;
    logic [`TRDB_PLEN_LEN-1:0]     packet_length_o;
    logic [`TRDB_PAYLOAD_LEN-1:0]  packet_payload_o;

    // expected packet: valid, format, subformat, length, payload
    logic [80:0]                   exp_next;
    logic [80:0]                   exp_pend;
    logic [80:0]                   exp_out;
    logic [31:0]                   rng;
    // model of the encoder state
    logic                          m_last_qual;
    logic                          m_last_exc;
    logic                          m_last_upd;
    logic                          m_last_intr;
    logic [`TRDB_PRIV_LEN-1:0]     m_last_priv;
    logic [`TRDB_CAUSE_LEN-1:0]    m_last_cause;
    logic [`TRDB_XLEN-1:0]         m_last_tval;
    logic [`TRDB_BMAP_LEN-1:0]     m_map;
    int                            m_count;
    int                            m_resync;
    int                            hit_start;
    int                            hit_trap;
    int                            hit_addr;
    int                            hit_branch;
    int                            cur_priv;
    logic [31:0]                   r;

    trace_debugger UUT (.*);

    always #(PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check_field(input string name, input logic [71:0] exp_v,
                               input logic [71:0] act_v);
        assert (act_v === exp_v) else begin
            $display("Fail at time %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    // follows the priority rules for the instruction now on the inputs
    task automatic model_step();
        logic [`TRDB_BMAP_LEN-1:0]  map_s;
        int                         cnt_s;
        logic                       qual;
        logic                       first;
        logic                       emit;
        logic                       sync;
        logic [1:0]                 fmt;
        logic [1:0]                 sub;
        logic [3:0]                 len;
        logic [71:0]                pay;
        exp_next = '0;
        if (inst_valid_i) begin
            qual  = trace_enable_i;
            first = qual & ~m_last_qual;
            map_s = m_map;
            cnt_s = m_count;
            emit  = 1'b0;
            sync  = 1'b0;
            fmt   = '0;
            sub   = '0;
            len   = '0;
            pay   = '0;
            // own branch outcome joins the map, not taken as 1
            if (qual && branch_i && cnt_s < `TRDB_BMAP_LEN) begin
                map_s[cnt_s[4:0]] = ~branch_taken_i;
                cnt_s             = cnt_s + 1;
            end
            if (qual) begin
                if (first || m_last_exc || priv_lvl_i != m_last_priv
                        || m_resync == `TRDB_RESYNC_MAX - 1) begin
                    emit = 1'b1;
                    sync = 1'b1;
                    fmt  = trdb_pkg::F_SYNC;
                    if (!first && m_last_exc) begin
                        sub = trdb_pkg::SF_TRAP;
                        len = 4'd9;
                        pay = {m_last_tval, m_last_cause, m_last_intr, pc_i, priv_lvl_i};
                        hit_trap++;
                    end else begin
                        sub = trdb_pkg::SF_START;
                        len = 4'd5;
                        pay = 72'({pc_i, priv_lvl_i});
                        hit_start++;
                    end
                end else if (m_last_upd || cnt_s == `TRDB_BMAP_LEN) begin
                    emit = 1'b1;
                    if (m_last_upd && cnt_s == 0) begin
                        fmt = trdb_pkg::F_ADDR_ONLY;
                        len = 4'd4;
                        pay = 72'(pc_i);
                        hit_addr++;
                    end else begin
                        fmt = trdb_pkg::F_BRANCH_FULL;
                        len = 4'd9;
                        pay = 72'({pc_i, map_s, 5'(cnt_s)});
                        hit_branch++;
                    end
                end
                m_resync = sync ? 0 : m_resync + 1;
                m_map    = emit ? '0 : map_s;
                m_count  = emit ? 0 : cnt_s;
            end
            if (emit) begin
                exp_next = {1'b1, fmt, sub, len, pay};
            end
            m_last_qual  = qual;
            m_last_exc   = exception_i;
            m_last_upd   = updiscon_i;
            m_last_priv  = priv_lvl_i;
            m_last_intr  = interrupt_i;
            m_last_cause = cause_i;
            m_last_tval  = tval_i;
        end
    endtask

    // one instruction slot, driven just after the rising edge
    task automatic drive(input int v, input int en, input int exc, input int priv,
                         input int br, input int upd);
        logic [31:0] s;
        @(posedge clk_i);
        #1;
        s              = next_rand();
        inst_valid_i   = (v != 0);
        trace_enable_i = (en != 0);
        exception_i    = (exc != 0);
        priv_lvl_i     = 2'(priv);
        branch_i       = (br != 0);
        updiscon_i     = (upd != 0);
        pc_i           = {s[31:2], 2'b00};
        tval_i         = next_rand();
        s              = next_rand();
        cause_i        = s[20:16];
        interrupt_i    = s[24];
        branch_taken_i = s[27];
        model_step();
    endtask

    // packet leaves two edges after its instruction was sampled
    always @(posedge clk_i) begin
        exp_out  <= exp_pend;
        exp_pend <= exp_next;
    end

    always @(negedge clk_i) begin
        check_field("packet_valid_o", 72'(exp_out[80]), 72'(packet_valid_o));
        check_field("packet_format_o", 72'(exp_out[79:78]), 72'(packet_format_o));
        check_field("packet_subformat_o", 72'(exp_out[77:76]), 72'(packet_subformat_o));
        check_field("packet_length_o", 72'(exp_out[75:72]), 72'(packet_length_o));
        check_field("packet_payload_o", exp_out[71:0], packet_payload_o);
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: stimulus did not finish within %0d time units", TIMEOUT);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_ni = 1'b0;
        inst_valid_i = 1'b0;
        trace_enable_i = 1'b0;
        exception_i = 1'b0;
        interrupt_i = 1'b0;
        cause_i = '0;
        tval_i = '0;
        priv_lvl_i = 2'(`TRDB_PRIV_RESET);
        pc_i = '0;
        branch_i = 1'b0;
        branch_taken_i = 1'b0;
        updiscon_i = 1'b0;
        exp_next = '0;
        exp_pend = '0;
        exp_out = '0;
        rng = 32'hbddc;
        m_last_qual = 1'b0;
        m_last_exc = 1'b0;
        m_last_upd = 1'b0;
        m_last_intr = 1'b0;
        m_last_priv = 2'(`TRDB_PRIV_RESET);
        m_last_cause = '0;
        m_last_tval = '0;
        m_map = '0;
        m_count = 0;
        m_resync = 0;
        hit_start = 0;
        hit_trap = 0;
        hit_addr = 0;
        hit_branch = 0;
        cur_priv = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // tracing off, nothing qualifies
        repeat (5) drive(1, 0, 0, 3, 0, 0);
        // first qualified gives a start packet
        drive(1, 1, 0, 3, 0, 0);
        drive(1, 1, 0, 3, 0, 0);
        // exception, then the trap packet on the next one
        drive(1, 1, 1, 3, 0, 0);
        drive(1, 1, 0, 3, 0, 0);
        // drop to user mode
        drive(1, 1, 0, 0, 0, 0);
        // long enough to force a resync, gaps do not count
        repeat (10) drive(1, 1, 0, 0, 0, 0);
        drive(0, 1, 0, 0, 0, 0);
        drive(0, 1, 0, 0, 0, 0);
        repeat (10) drive(1, 1, 0, 0, 0, 0);
        // jump with an empty map
        drive(1, 1, 0, 0, 0, 1);
        drive(1, 1, 0, 0, 0, 0);
        // jump after some branches
        repeat (4) drive(1, 1, 0, 0, 1, 0);
        drive(1, 1, 0, 0, 0, 1);
        drive(1, 1, 0, 0, 1, 0);
        // resync fires every 16 qualified, so the map never fills
        repeat (40) drive(1, 1, 0, 0, 1, 0);
        repeat (RAND_COUNT) begin
            r = next_rand();
            if (r[23:21] == 3'd0) begin
                cur_priv = int'(r[19:18]);
            end
            drive((r[17:16] != 2'd0) ? 1 : 0, (r[31:28] != 4'd0) ? 1 : 0,
                  (r[27:24] == 4'd0) ? 1 : 0, cur_priv, r[15] ? 1 : 0,
                  (r[14:12] == 3'd0) ? 1 : 0);
        end
        repeat (4) drive(0, 0, 0, cur_priv, 0, 0);
        @(negedge clk_i);
        if (hit_start > 0 && hit_trap > 0 && hit_addr > 0 && hit_branch > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("a packet kind was never exercised by the stimulus");
            $display("RESULT: FAIL");
            $fatal(1, "end of run check failed");
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
source/trdb_pkg.sv
source/trdb_decode.sv
source/trdb_branch_map.sv
source/trdb_execute.sv
source/trdb_result.sv
source/trace_debugger.sv
verification/trdb_properties.sv
verification/trdb_tb.sv

//--- Makefile
# Verilator build and run of the trace encoder testbench

VERILATOR ?= verilator
TOP       ?= trdb_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
